/* Bender.yml */
package:
  name: pipe_ctrl

sources:
  # design, in compile order
  - logic/pipe_ctrl_pkg.sv
  - logic/hazard_ctrl_if.sv
  - logic/trap_pipe_if.sv
  - logic/wb_master.sv
  - logic/fetch_stage.sv
  - logic/hazard_unit.sv
  - logic/trap_unit.sv
  - logic/pipe_ctrl_top.sv

  # testbench
  - target: simulation
    files:
      - sim/pipe_ctrl_tb.sv

/* logic/fetch_stage.sv */
// fetch_stage: pc register, instruction fetch, one-entry holding slot and fetch/execute register
`default_nettype none

module fetch_stage #(
  parameter pipe_ctrl_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  logic                 clk,
  input  logic                 rst_n,
  hazard_ctrl_if.fetch         hz,
  input  pipe_ctrl_pkg::word_t target,
  // instruction bus
  output logic                 i_cyc,
  output logic                 i_stb,
  output pipe_ctrl_pkg::word_t i_adr,
  input  logic                 i_ack,
  input  pipe_ctrl_pkg::word_t i_dat_r,
  // fetch/execute register
  output logic                 ex_valid,
  output pipe_ctrl_pkg::word_t ex_pc,
  output pipe_ctrl_pkg::word_t ex_insn
);
  import pipe_ctrl_pkg::*;

  word_t pc;
  word_t npc;
  logic  i_req;
  logic  i_done;
  word_t i_rdata;
  // in-flight fetch belongs to a flushed path
  logic  kill;
  // word fetched while execute was stalled
  logic  hold_valid;
  word_t hold_pc;
  word_t hold_insn;
  // word available to enter execute this cycle
  logic  fetch_ready;
  word_t fetch_pc;
  word_t fetch_insn;

  // low address bits set, never sent to the bus
  assign hz.mal_insn  = pc[1:0] != 2'b00;
  assign hz.epc_f     = pc;
  assign hz.badaddr_f = pc;
  assign hz.token_ex  = ex_valid;

  // no new fetch while the slot is full
  assign i_req = hz.iren & ~hold_valid & ~hz.mal_insn;

  wb_master imem_master_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (i_req),
    .we       (1'b0),
    .adr      (pc),
    .dat_w    ('0),
    .sel      (4'hf),
    .rdata    (i_rdata),
    .done     (i_done),
    .busy     (),
    .cyc      (i_cyc),
    .stb      (i_stb),
    .wb_we    (),
    .wb_adr   (i_adr),
    .wb_dat_w (),
    .wb_sel   (),
    .ack      (i_ack),
    .dat_r    (i_dat_r)
  );

  // held word first, it is older than anything on the bus
  assign fetch_ready   = (i_done & ~kill) | hold_valid;
  assign fetch_pc      = hold_valid ? hold_pc : i_adr;
  assign fetch_insn    = hold_valid ? hold_insn : i_rdata;
  assign hz.i_mem_busy = ~fetch_ready;

  // trap / mret target beats a redirect, which beats sequential
  always_comb begin
    if (hz.insert_priv_pc) begin
      npc = hz.priv_pc;
    end else if (hz.npc_sel) begin
      npc = target;
    end else begin
      npc = pc + 32'd4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc         <= reset_pc;
      kill       <= 1'b0;
      hold_valid <= 1'b0;
      ex_valid   <= 1'b0;
    end else begin
      if (hz.pc_en) begin
        pc <= npc;
      end
      // flush during a transfer, drop its word when ack comes
      if (i_done) begin
        kill <= 1'b0;
      end else if (hz.if_ex_flush && i_cyc) begin
        kill <= 1'b1;
      end
      // slot fills only while execute holds
      if (hz.if_ex_flush || !hz.if_ex_stall) begin
        hold_valid <= 1'b0;
      end else if (i_done && !kill) begin
        hold_valid <= 1'b1;
      end
      // bubble when nothing is ready
      if (hz.if_ex_flush) begin
        ex_valid <= 1'b0;
      end else if (!hz.if_ex_stall) begin
        ex_valid <= fetch_ready;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_done && !hold_valid) begin
      hold_pc   <= i_adr;
      hold_insn <= i_rdata;
    end
    if (!hz.if_ex_stall && fetch_ready) begin
      ex_pc   <= fetch_pc;
      ex_insn <= fetch_insn;
    end
  end

endmodule

`default_nettype wire

/* logic/hazard_ctrl_if.sv */
// hazard_ctrl_if: stall, flush and next-pc control between the hazard unit and the fetch stage
`default_nettype none

interface hazard_ctrl_if;
  import pipe_ctrl_pkg::*;

  // pc update and next-pc source
  logic  pc_en;
  logic  npc_sel;
  // fetch/execute register control
  logic  if_ex_stall;
  logic  if_ex_flush;
  // instruction fetch allowed this cycle
  logic  iren;
  // trap or mret target overrides everything else
  logic  insert_priv_pc;
  word_t priv_pc;

  // fetch side status
  logic  i_mem_busy;
  logic  token_ex;
  logic  mal_insn;
  // pc and bad address of a failing fetch
  word_t epc_f;
  word_t badaddr_f;

  modport hazard (
    output pc_en, npc_sel, if_ex_stall, if_ex_flush, iren, insert_priv_pc, priv_pc,
    input  i_mem_busy, token_ex, mal_insn, epc_f, badaddr_f
  );

  modport fetch (
    input  pc_en, npc_sel, if_ex_stall, if_ex_flush, iren, insert_priv_pc, priv_pc,
    output i_mem_busy, token_ex, mal_insn, epc_f, badaddr_f
  );

endinterface

`default_nettype wire

/* logic/hazard_unit.sv */
// hazard_unit: stall, flush, pc-enable and retire decisions for the two-stage pipeline
`default_nettype none

module hazard_unit (
  hazard_ctrl_if.hazard            hz,
  trap_pipe_if.hazard              tp,
  // execute stage
  input  logic                     ex_valid,
  input  logic                     jump,
  input  logic                     branch,
  input  logic                     mispredict,
  input  logic                     halt,
  input  logic                     mret,
  input  logic                     dren,
  input  logic                     dwen,
  input  pipe_ctrl_pkg::ex_flags_t ex_flags,
  input  pipe_ctrl_pkg::word_t     ex_pc,
  input  pipe_ctrl_pkg::word_t     daddr,
  // data bus status
  input  logic                     d_busy,
  output logic                     ex_retire
);

  // pipeline hazards
  logic dmem_access;
  logic branch_jump;
  logic wait_for_imem;
  logic wait_for_dmem;
  logic ex_halt;
  logic ret;

  // trap hazards
  logic ex_flush_hazard;
  logic e_ex_stage;
  logic e_f_stage;
  logic intr;

  // execute answers only count with a valid instruction
  assign dmem_access   = ex_valid & (dren | dwen);
  assign branch_jump   = ex_valid & (jump | (branch & mispredict));
  assign ex_halt       = ex_valid & halt;
  assign ret           = ex_valid & mret;
  assign wait_for_imem = hz.iren & hz.i_mem_busy;
  assign wait_for_dmem = dmem_access & d_busy;

  // exception sources per stage
  assign e_ex_stage = ex_valid & (|ex_flags);
  assign e_f_stage  = hz.mal_insn;
  // interrupt loses to any synchronous exception
  assign intr       = ~e_ex_stage & ~e_f_stage & tp.intr;

  // a fetch fault waits for an outstanding data access
  assign ex_flush_hazard = (e_f_stage & ~wait_for_dmem) | intr | e_ex_stage | ret;

  assign hz.npc_sel     = branch_jump;
  assign hz.if_ex_flush = ex_flush_hazard | branch_jump;
  // execute holds on data wait or halt, unless a trap takes over
  assign hz.if_ex_stall = (wait_for_dmem | ex_halt) & ~ex_flush_hazard;

  // pc moves when a fetched word is consumed or on any redirect
  assign hz.pc_en = (~wait_for_imem & ~wait_for_dmem & ~ex_halt & ~ex_flush_hazard) |
                    branch_jump | tp.insert_pc | ret;

  // no wrong-path fetch in a redirect cycle
  assign hz.iren = ~hz.if_ex_flush;

  assign hz.insert_priv_pc = tp.insert_pc;
  assign hz.priv_pc        = tp.priv_pc;

  // interrupt only on an instruction with no data access
  assign tp.pipe_clear = hz.token_ex & ~dmem_access;

  // completes unless stalled, faulting or interrupted
  assign tp.retire = ex_valid & ~hz.if_ex_stall & ~e_ex_stage & ~intr;
  assign ex_retire = tp.retire;

  // exception notifications for the trap unit
  assign tp.ex_flags = ex_valid ? ex_flags : '0;
  assign tp.mal_insn = e_f_stage & ~wait_for_dmem;
  assign tp.intr_ack = intr;
  assign tp.ret      = ret;

  // fetch fault reports the fetch pc, everything else the execute pc
  assign tp.epc     = e_f_stage ? hz.epc_f : ex_pc;
  assign tp.badaddr = e_f_stage ? hz.badaddr_f : daddr;

endmodule

`default_nettype wire

/* logic/pipe_ctrl_pkg.sv */
// pipe_ctrl_pkg: word, trap cause and execute-stage exception types for the pipeline control
`default_nettype none

package pipe_ctrl_pkg;

  // one machine word
  // used for fetch addresses, data addresses and data alike
  typedef logic [31:0] word_t;

  // mcause encodings
  // bit 31 set marks an interrupt, the rest are synchronous exceptions
  typedef enum logic [31:0] {
    misaligned_fetch = 32'h0000_0000,
    illegal_insn     = 32'h0000_0002,
    breakpoint       = 32'h0000_0003,
    misaligned_load  = 32'h0000_0004,
    misaligned_store = 32'h0000_0006,
    ecall_m          = 32'h0000_000b,
    machine_ext_irq  = 32'h8000_000b
  } cause_t;

  // exceptions reported for the instruction sitting in execute
  typedef struct packed {
    // undecodable opcode
    logic illegal_insn;
    // ebreak
    logic breakpoint;
    // ecall from machine mode
    logic env_m;
    // load / store address not naturally aligned
    logic mal_l;
    logic mal_s;
  } ex_flags_t;

endpackage

`default_nettype wire

/* logic/pipe_ctrl_top.sv */
// pipe_ctrl_top: two-stage pipeline control with fetch, hazard, trap logic and two Wishbone masters
`default_nettype none

module pipe_ctrl_top #(
  parameter pipe_ctrl_pkg::word_t reset_pc    = 32'h0000_0000,
  parameter pipe_ctrl_pkg::word_t trap_vector = 32'h0000_0100
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     irq,
  // decoded execute-stage control
  input  logic                     jump,
  input  logic                     branch,
  input  logic                     mispredict,
  input  pipe_ctrl_pkg::word_t     target,
  input  logic                     dren,
  input  logic                     dwen,
  input  pipe_ctrl_pkg::word_t     daddr,
  input  pipe_ctrl_pkg::word_t     dwdata,
  input  logic                     halt,
  input  logic                     mret,
  input  pipe_ctrl_pkg::ex_flags_t ex_flags,
  // instruction in execute
  output logic                     ex_valid,
  output pipe_ctrl_pkg::word_t     ex_pc,
  output pipe_ctrl_pkg::word_t     ex_insn,
  output logic                     ex_retire,
  // trap report
  output logic                     trap_taken,
  output pipe_ctrl_pkg::cause_t    trap_cause,
  output pipe_ctrl_pkg::word_t     trap_epc,
  output pipe_ctrl_pkg::word_t     trap_val,
  // instruction wishbone
  output logic                     i_cyc,
  output logic                     i_stb,
  output pipe_ctrl_pkg::word_t     i_adr,
  input  logic                     i_ack,
  input  pipe_ctrl_pkg::word_t     i_dat_r,
  // data wishbone
  output logic                     d_cyc,
  output logic                     d_stb,
  output logic                     d_we,
  output pipe_ctrl_pkg::word_t     d_adr,
  output pipe_ctrl_pkg::word_t     d_dat_w,
  output logic [3:0]               d_sel,
  input  logic                     d_ack,
  input  pipe_ctrl_pkg::word_t     d_dat_r
);

  hazard_ctrl_if hz_if ();
  trap_pipe_if   tp_if ();

  logic d_req;
  logic d_busy;

  // faulting loads and stores never reach the bus
  assign d_req = ex_valid & (dren | dwen) & ~(|ex_flags);

  fetch_stage #(.reset_pc(reset_pc)) fetch_stage_i (
    .clk (clk), .rst_n (rst_n), .hz (hz_if.fetch), .target (target),
    .i_cyc (i_cyc), .i_stb (i_stb), .i_adr (i_adr), .i_ack (i_ack), .i_dat_r (i_dat_r),
    .ex_valid (ex_valid), .ex_pc (ex_pc), .ex_insn (ex_insn)
  );

  hazard_unit hazard_unit_i (
    .hz (hz_if.hazard), .tp (tp_if.hazard), .ex_valid (ex_valid),
    .jump (jump), .branch (branch), .mispredict (mispredict), .halt (halt), .mret (mret),
    .dren (dren), .dwen (dwen), .ex_flags (ex_flags), .ex_pc (ex_pc), .daddr (daddr),
    .d_busy (d_busy), .ex_retire (ex_retire)
  );

  trap_unit #(.trap_vector(trap_vector)) trap_unit_i (
    .clk (clk), .rst_n (rst_n), .tp (tp_if.trap), .irq (irq),
    .trap_taken (trap_taken), .trap_cause (trap_cause),
    .trap_epc (trap_epc), .trap_val (trap_val)
  );

  // word accesses only, all byte lanes
  wb_master dmem_master_i (
    .clk (clk), .rst_n (rst_n), .req (d_req), .we (dwen), .adr (daddr), .dat_w (dwdata),
    .sel (4'hf), .rdata (), .done (), .busy (d_busy),
    .cyc (d_cyc), .stb (d_stb), .wb_we (d_we), .wb_adr (d_adr), .wb_dat_w (d_dat_w),
    .wb_sel (d_sel), .ack (d_ack), .dat_r (d_dat_r)
  );

endmodule

`default_nettype wire

/* logic/trap_pipe_if.sv */
// trap_pipe_if: exception context and trap redirect between the hazard unit and the trap unit
`default_nettype none

interface trap_pipe_if;
  import pipe_ctrl_pkg::*;

  // pipeline state as seen by the trap unit
  logic      pipe_clear;
  logic      retire;
  // exception sources, already qualified by the hazard unit
  ex_flags_t ex_flags;
  logic      mal_insn;
  logic      intr_ack;
  logic      ret;
  // trap context
  word_t     epc;
  word_t     badaddr;

  // trap unit answers
  logic      intr;
  logic      insert_pc;
  word_t     priv_pc;

  modport hazard (
    output pipe_clear, retire, ex_flags, mal_insn, intr_ack, ret, epc, badaddr,
    input  intr, insert_pc, priv_pc
  );

  modport trap (
    input  pipe_clear, retire, ex_flags, mal_insn, intr_ack, ret, epc, badaddr,
    output intr, insert_pc, priv_pc
  );

endinterface

`default_nettype wire

/* logic/trap_unit.sv */
// trap_unit: machine trap registers, interrupt gating, trap vector and mret return pc
`default_nettype none

module trap_unit #(
  parameter pipe_ctrl_pkg::word_t trap_vector = 32'h0000_0100
) (
  input  logic                  clk,
  input  logic                  rst_n,
  trap_pipe_if.trap             tp,
  // external interrupt line
  input  logic                  irq,
  output logic                  trap_taken,
  output pipe_ctrl_pkg::cause_t trap_cause,
  output pipe_ctrl_pkg::word_t  trap_epc,
  output pipe_ctrl_pkg::word_t  trap_val
);
  import pipe_ctrl_pkg::*;

  // machine state
  logic   mie;
  word_t  mepc;
  cause_t mcause;
  word_t  mtval;

  // values written on a trap this cycle
  cause_t cause_next;
  word_t  val_next;

  // enabled interrupt, only at a clean instruction boundary
  assign tp.intr = irq & mie & tp.pipe_clear;

  // any qualified source takes a trap
  assign trap_taken = tp.mal_insn | (|tp.ex_flags) | tp.intr_ack;

  // fixed priority, fetch fault first and interrupt last
  always_comb begin
    cause_next = machine_ext_irq;
    val_next   = '0;
    if (tp.mal_insn) begin
      cause_next = misaligned_fetch;
      val_next   = tp.badaddr;
    end else if (tp.ex_flags.illegal_insn) begin
      cause_next = illegal_insn;
    end else if (tp.ex_flags.breakpoint) begin
      // faulting pc for ebreak
      cause_next = breakpoint;
      val_next   = tp.epc;
    end else if (tp.ex_flags.env_m) begin
      cause_next = ecall_m;
    end else if (tp.ex_flags.mal_l) begin
      cause_next = misaligned_load;
      val_next   = tp.badaddr;
    end else if (tp.ex_flags.mal_s) begin
      cause_next = misaligned_store;
      val_next   = tp.badaddr;
    end
  end

  // live trap context in the trap cycle, stored csrs otherwise
  assign trap_cause = trap_taken ? cause_next : mcause;
  assign trap_epc   = trap_taken ? tp.epc : mepc;
  assign trap_val   = trap_taken ? val_next : mtval;

  // trap goes to the vector, mret back to mepc
  assign tp.insert_pc = trap_taken | tp.ret;
  assign tp.priv_pc   = trap_taken ? trap_vector : mepc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie    <= 1'b1;
      mepc   <= '0;
      mcause <= misaligned_fetch;
      mtval  <= '0;
    end else if (trap_taken) begin
      // handler runs with interrupts masked
      mie    <= 1'b0;
      mepc   <= tp.epc;
      mcause <= cause_next;
      mtval  <= val_next;
    end else if (tp.ret && tp.retire) begin
      mie <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/wb_master.sv */
// wb_master: Wishbone classic master that runs one single transfer at a time until ack
`default_nettype none

module wb_master (
  input  logic                 clk,
  input  logic                 rst_n,
  // request side
  input  logic                 req,
  input  logic                 we,
  input  pipe_ctrl_pkg::word_t adr,
  input  pipe_ctrl_pkg::word_t dat_w,
  input  logic [3:0]           sel,
  output pipe_ctrl_pkg::word_t rdata,
  output logic                 done,
  output logic                 busy,
  // wishbone side
  output logic                 cyc,
  output logic                 stb,
  output logic                 wb_we,
  output pipe_ctrl_pkg::word_t wb_adr,
  output pipe_ctrl_pkg::word_t wb_dat_w,
  output logic [3:0]           wb_sel,
  input  logic                 ack,
  input  pipe_ctrl_pkg::word_t dat_r
);

  // single state bit, high from request start through the ack cycle
  logic active;

  // cyc and stb move together in classic single transfers
  assign cyc = active;
  assign stb = active;

  // transfer ends in the cycle ack is sampled
  assign done  = active & ack;
  // read data valid only alongside done
  assign rdata = dat_r;
  // requester must wait until the ack cycle
  assign busy  = req & ~done;

  // start when idle, drop the cycle after ack
  // no back-to-back restart from the ack cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      wb_we  <= 1'b0;
    end else if (!active) begin
      if (req) begin
        active <= 1'b1;
        wb_we  <= we;
      end
    end else if (ack) begin
      active <= 1'b0;
    end
  end

  // address, write data and byte lanes frozen for the whole transfer
  always_ff @(posedge clk) begin
    if (!active && req) begin
      wb_adr   <= adr;
      wb_dat_w <= dat_w;
      wb_sel   <= sel;
    end
  end

endmodule

`default_nettype wire

/* sim/pipe_ctrl_tb.sv */
// pipe_ctrl_tb: random execute-stage and Wishbone slave stimulus against a pipeline reference model
`default_nettype none

module pipe_ctrl_tb;
  import pipe_ctrl_pkg::*;

  localparam word_t reset_pc    = 32'h0000_0200;
  localparam word_t trap_vector = 32'h0000_0800;
  localparam int    num_cycles  = 4000;
  localparam int    idle_limit  = 64;

  logic      clk;
  logic      rst_n;
  logic      irq;
  logic      jump;
  logic      branch;
  logic      mispredict;
  word_t     target;
  logic      dren;
  logic      dwen;
  word_t     daddr;
  word_t     dwdata;
  logic      halt;
  logic      mret;
  ex_flags_t ex_flags;
  logic      ex_valid;
  word_t     ex_pc;
  word_t     ex_insn;
  logic      ex_retire;
  logic      trap_taken;
  cause_t    trap_cause;
  word_t     trap_epc;
  word_t     trap_val;
  logic      i_cyc;
  logic      i_stb;
  word_t     i_adr;
  logic      i_ack;
  word_t     i_dat_r;
  logic      d_cyc;
  logic      d_stb;
  logic      d_we;
  word_t     d_adr;
  word_t     d_dat_w;
  logic [3:0] d_sel;
  logic      d_ack;
  word_t     d_dat_r;

  // reference model state
  word_t exp_fetch;
  word_t exp_ex_pc;
  word_t m_mepc;
  logic  m_mie;
  logic  stalled;
  logic  mal_pend;
  word_t mal_addr;
  logic  prev_i_cyc;
  logic  irq_served;
  string fetch_name;
  string ex_name;
  // slave wait states left
  int    i_wait;
  int    d_wait;
  int    idle;
  int    cycle;
  int    checks;
  int    errors;
  int    timeouts;
  logic  timed_out;

  pipe_ctrl_top #(.reset_pc(reset_pc), .trap_vector(trap_vector)) dut_i (
    .clk (clk), .rst_n (rst_n), .irq (irq),
    .jump (jump), .branch (branch), .mispredict (mispredict), .target (target),
    .dren (dren), .dwen (dwen), .daddr (daddr), .dwdata (dwdata),
    .halt (halt), .mret (mret), .ex_flags (ex_flags),
    .ex_valid (ex_valid), .ex_pc (ex_pc), .ex_insn (ex_insn), .ex_retire (ex_retire),
    .trap_taken (trap_taken), .trap_cause (trap_cause), .trap_epc (trap_epc),
    .trap_val (trap_val),
    .i_cyc (i_cyc), .i_stb (i_stb), .i_adr (i_adr), .i_ack (i_ack), .i_dat_r (i_dat_r),
    .d_cyc (d_cyc), .d_stb (d_stb), .d_we (d_we), .d_adr (d_adr), .d_dat_w (d_dat_w),
    .d_sel (d_sel), .d_ack (d_ack), .d_dat_r (d_dat_r)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // instruction memory contents, a hash of the full address
  function automatic word_t insn_word(input word_t addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
  endfunction

  // synchronous causes by fixed priority
  function automatic cause_t flag_cause(input ex_flags_t f);
    if (f.illegal_insn) return illegal_insn;
    if (f.breakpoint) return breakpoint;
    if (f.env_m) return ecall_m;
    if (f.mal_l) return misaligned_load;
    return misaligned_store;
  endfunction

  function automatic word_t rand_target();
    word_t t;
    t = $urandom & 32'h0000_fffc;
    // now and then a target that cannot be fetched
    if ($urandom % 12 == 0) begin
      t[1:0] = 2'($urandom % 3 + 1);
    end
    return t;
  endfunction

  // both slaves draw 0 to 3 wait states while idle
  task automatic drive_slaves();
    i_ack   = i_cyc && i_wait == 0;
    i_dat_r = i_ack ? insn_word(i_adr) : '0;
    if (!i_cyc) begin
      i_wait = $urandom % 4;
    end else if (i_wait > 0) begin
      i_wait--;
    end
    d_ack = d_cyc && d_wait == 0;
    if (!d_cyc) begin
      d_wait = $urandom % 4;
    end else if (d_wait > 0) begin
      d_wait--;
    end
  endtask

  // execute-stage answers for the instruction now in execute
  task automatic drive_exec();
    int kind;
    kind = $urandom % 16;
    // a stalled load or store keeps its answers
    if (!stalled) begin
      jump       = 1'b0;
      branch     = 1'b0;
      mispredict = 1'b0;
      target     = '0;
      dren       = 1'b0;
      dwen       = 1'b0;
      daddr      = '0;
      dwdata     = '0;
      mret       = 1'b0;
      ex_flags   = '0;
      if (ex_valid) begin
        case (kind)
          6: begin
            jump   = 1'b1;
            target = rand_target();
          end
          7, 8: begin
            branch     = 1'b1;
            mispredict = 1'($urandom % 2);
            target     = rand_target();
          end
          9, 10: begin
            dren  = 1'b1;
            daddr = $urandom & 32'hffff_fffc;
          end
          11, 12: begin
            dwen   = 1'b1;
            daddr  = $urandom & 32'hffff_fffc;
            dwdata = $urandom;
          end
          13: ex_flags = ex_flags_t'(5'($urandom % 31 + 1));
          14, 15: begin
            // handler returns only to a fetchable epc
            mret = !m_mie && m_mepc[1:0] == 2'b00;
          end
          default: ;
        endcase
      end
    end
  endtask

  // irq stays up for a while after it was taken
  task automatic drive_irq();
    if (!irq) begin
      irq = ($urandom % 24 == 0);
    end else if (irq_served && $urandom % 6 == 0) begin
      irq        = 1'b0;
      irq_served = 1'b0;
    end
  endtask

  task automatic check_cycle();
    logic   dmem;
    logic   exp_trap;
    logic   exp_retire;
    logic   is_irq;
    cause_t exp_cause;
    word_t  exp_epc;
    word_t  exp_val;
    string  trap_name;
    // each new instruction bus cycle
    if (i_cyc && !prev_i_cyc) begin
      compare(fetch_name, exp_fetch, i_adr);
      exp_fetch  = exp_fetch + 32'd4;
      fetch_name = "seq_fetch";
    end
    prev_i_cyc = i_cyc;
    if (ex_valid) begin
      idle = 0;
      if (stalled) begin
        compare("data_stall", exp_ex_pc, ex_pc);
      end else begin
        compare(ex_name, exp_ex_pc, ex_pc);
        ex_name = "seq_fetch";
      end
      compare("seq_fetch", insn_word(exp_ex_pc), ex_insn);
    end else begin
      idle++;
    end
    // data bus cycle open exactly while an earlier access is unanswered
    compare("data_stall", {stalled, stalled}, {d_cyc, d_stb});
    // data bus carries the responder's request
    if (d_cyc) begin
      compare("data_stall", daddr, d_adr);
      compare("data_stall", dwen, d_we);
      compare("data_stall", 4'hf, d_sel);
      if (dwen) begin
        compare("data_stall", dwdata, d_dat_w);
      end
    end
    dmem      = ex_valid & (dren | dwen);
    exp_trap  = 1'b0;
    is_irq    = 1'b0;
    exp_cause = machine_ext_irq;
    exp_epc   = exp_ex_pc;
    if (mal_pend) begin
      exp_trap  = 1'b1;
      exp_cause = misaligned_fetch;
      exp_epc   = mal_addr;
    end else if (ex_valid && ex_flags != '0) begin
      exp_trap  = 1'b1;
      exp_cause = flag_cause(ex_flags);
    end else if (ex_valid && irq && m_mie && !dmem) begin
      exp_trap = 1'b1;
      is_irq   = 1'b1;
    end
    // faulting address for misaligned accesses, pc for ebreak
    case (exp_cause)
      misaligned_fetch:                  exp_val = mal_addr;
      breakpoint:                        exp_val = exp_ex_pc;
      misaligned_load, misaligned_store: exp_val = daddr;
      default:                           exp_val = '0;
    endcase
    trap_name  = is_irq ? "interrupt" : "exception";
    exp_retire = ex_valid & ~exp_trap & ~(dmem & ~(d_cyc & d_ack));
    compare(trap_name, exp_trap, trap_taken);
    compare("data_stall", exp_retire, ex_retire);
    if (exp_trap) begin
      compare(trap_name, exp_cause, trap_cause);
      compare(trap_name, exp_epc, trap_epc);
      compare(trap_name, exp_val, trap_val);
    end
    // advance the model
    mal_pend = 1'b0;
    stalled  = ex_valid & ~exp_trap & dmem & ~(d_cyc & d_ack);
    if (exp_trap) begin
      m_mie      = 1'b0;
      m_mepc     = exp_epc;
      exp_fetch  = trap_vector;
      exp_ex_pc  = trap_vector;
      fetch_name = trap_name;
      ex_name    = trap_name;
      irq_served = irq_served | is_irq;
    end else if (exp_retire && mret) begin
      m_mie      = 1'b1;
      exp_fetch  = m_mepc;
      exp_ex_pc  = m_mepc;
      fetch_name = "trap_return";
      ex_name    = "trap_return";
    end else if (exp_retire && (jump || (branch && mispredict))) begin
      exp_fetch  = target;
      exp_ex_pc  = target;
      fetch_name = "redirect";
      ex_name    = "redirect";
      // unfetchable target traps in the next cycle
      mal_pend   = target[1:0] != 2'b00;
      mal_addr   = target;
    end else if (exp_retire) begin
      exp_ex_pc = exp_ex_pc + 32'd4;
    end
    if (idle > idle_limit) begin
      $display("timeout: no instruction reached execute within %0d cycles", idle_limit);
      timeouts++;
      timed_out = 1'b1;
    end
  endtask

  initial begin
    void'($urandom(74291));
    rst_n      = 1'b0;
    irq        = 1'b0;
    halt       = 1'b0;
    i_ack      = 1'b0;
    i_dat_r    = '0;
    d_ack      = 1'b0;
    d_dat_r    = '0;
    exp_fetch  = reset_pc;
    exp_ex_pc  = reset_pc;
    m_mepc     = '0;
    m_mie      = 1'b1;
    stalled    = 1'b0;
    mal_pend   = 1'b0;
    mal_addr   = '0;
    prev_i_cyc = 1'b0;
    irq_served = 1'b0;
    fetch_name = "seq_fetch";
    ex_name    = "seq_fetch";
    i_wait     = $urandom % 4;
    d_wait     = $urandom % 4;
    idle       = 0;
    checks     = 0;
    errors     = 0;
    timeouts   = 0;
    timed_out  = 1'b0;
    drive_exec();
    repeat (4) @(posedge clk);
    // nothing moves while reset is held
    compare("reset", 5'b0, {i_cyc, d_cyc, ex_valid, ex_retire, trap_taken});
    #1 rst_n = 1'b1;
    cycle = 0;
    while (cycle < num_cycles && !timed_out) begin
      @(posedge clk);
      #1;
      drive_slaves();
      drive_exec();
      drive_irq();
      @(negedge clk);
      // first fetch right after reset release
      if (cycle == 0) begin
        compare("seq_fetch", 1'b1, i_stb);
      end
      check_cycle();
      cycle++;
    end
    $display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
logic/pipe_ctrl_pkg.sv
logic/hazard_ctrl_if.sv
logic/trap_pipe_if.sv
logic/wb_master.sv
logic/fetch_stage.sv
logic/hazard_unit.sv
logic/trap_unit.sv
logic/pipe_ctrl_top.sv
sim/pipe_ctrl_tb.sv
